// ==== uart_tx_pkg.sv ====
// Shared transmit types; word_len codes 0..3 select 5..8 data bits, OVERSAMPLE is fixed at 16
package uart_tx_pkg;

    // ======================================================================
    // Widths that carry a meaning
    // ======================================================================
    typedef logic [7:0]  uart_byte_t;       // Character as written by the host
    typedef logic [15:0] baud_div_t;        // Programmed baud divisor
    typedef logic [1:0]  word_len_t;        // 0..3 -> 5..8 data bits
    typedef logic [3:0]  oversample_cnt_t;  // Ticks within one bit period
    typedef logic [2:0]  bit_idx_t;         // Current data bit

    // Ticks of the baud generator per serial bit
    localparam int OVERSAMPLE = 16;

    // ======================================================================
    // Frame configuration
    // ======================================================================
    // Layout from MSB: word_len[1:0], two_stop, parity_en, even_parity,
    // stick_parity
    typedef struct packed {
        word_len_t word_len;      // Data bits minus five
        logic      two_stop;      // Second stop bit, ignored for 5-bit words
        logic      parity_en;     // Parity bit after the data
        logic      even_parity;   // Even when set, odd when clear
        logic      stick_parity;  // Parity bit fixed at ~even_parity
    } tx_frame_cfg_t;

    // ======================================================================
    // Serializer FSM
    // ======================================================================
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP1,
        TX_STOP2
    } tx_state_t;

endpackage : uart_tx_pkg

// ==== uart_baud_gen.sv ====
// Tick every divisor cycles; a divisor of 0 or 1 ticks every cycle, changes apply on the fly
module uart_baud_gen
    import uart_tx_pkg::*;
(
    input  logic      clk,
    input  logic      cmd_tx_fifo_reset,
    input  baud_div_t divisor,
    output logic      baud_tick
);

    // ======================================================================
    // Divider counter
    // ======================================================================
    baud_div_t r_count;
    baud_div_t w_count_last;   // Final count before the wrap
    logic      w_wrap;

    assign w_count_last = divisor - baud_div_t'(1);

    // Zero divisor would underflow the compare, so it wraps every cycle.
    // The >= also catches a divisor lowered below the running count.
    assign w_wrap = (divisor == '0) || (r_count >= w_count_last);

    always_ff @(posedge clk) begin
        if (cmd_tx_fifo_reset) begin
            r_count <= '0;
        end else if (w_wrap) begin
            r_count <= '0;
        end else begin
            r_count <= r_count + 1'b1;
        end
    end

    // One-cycle pulse at the start of each divisor period
    assign baud_tick = (r_count == '0);

endmodule : uart_baud_gen

// ==== uart_tx_fifo.sv ====
// Byte FIFO, FIFO_DEPTH a power of two >= 2; writes when full are dropped, pop expects data
module uart_tx_fifo
    import uart_tx_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       cmd_tx_fifo_reset,
    input  logic       tx_write,
    input  logic       fifo_pop,
    input  uart_byte_t tx_data,
    output uart_byte_t head_data,
    output logic       fifo_empty
);

    // ======================================================================
    // Pointer geometry
    // ======================================================================
    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int PTR_W  = ADDR_W + 1;           // Extra wrap bit

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [PTR_W-1:0]  ptr_t;

    localparam ptr_t FULL_COUNT = ptr_t'(FIFO_DEPTH);

    uart_byte_t r_mem [FIFO_DEPTH];
    ptr_t       r_wr_ptr;
    ptr_t       r_rd_ptr;
    ptr_t       w_count;
    logic       w_full;
    logic       w_do_write;
    logic       w_do_pop;
    addr_t      w_wr_addr;
    addr_t      w_rd_addr;

    // Fill level from the pointer difference
    assign w_count    = r_wr_ptr - r_rd_ptr;
    assign fifo_empty = (w_count == '0);
    assign w_full     = (w_count == FULL_COUNT);

    assign w_do_write = tx_write && !w_full;     // Overflow byte is lost
    assign w_do_pop   = fifo_pop && !fifo_empty;

    assign w_wr_addr = r_wr_ptr[ADDR_W-1:0];
    assign w_rd_addr = r_rd_ptr[ADDR_W-1:0];

    // ======================================================================
    // Pointers
    // ======================================================================
    always_ff @(posedge clk) begin
        if (cmd_tx_fifo_reset) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
        end else begin
            if (w_do_write) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (w_do_pop) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;  // Head retires at this edge
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (w_do_write) begin
            r_mem[w_wr_addr] <= tx_data;
        end
    end

    // Head entry is visible without a read latency
    assign head_data = r_mem[w_rd_addr];

endmodule : uart_tx_fifo

// ==== uart_tx_serializer.sv ====
// Frame is sampled live from frame_cfg; changing it mid-frame alters the current frame
module uart_tx_serializer
    import uart_tx_pkg::*;
(
    input  logic          clk,
    input  logic          cmd_tx_fifo_reset,
    input  logic          baud_tick,
    input  logic          set_break,
    input  logic          fifo_empty,
    input  tx_frame_cfg_t frame_cfg,
    input  uart_byte_t    head_data,
    output logic          fifo_pop,
    output logic          uart_tx,
    output logic          tx_empty
);

    localparam oversample_cnt_t OS_LAST = oversample_cnt_t'(OVERSAMPLE - 1);

    tx_state_t       r_state;
    uart_byte_t      r_shift;      // Data bits, LSB goes out first
    bit_idx_t        r_bit_idx;
    oversample_cnt_t r_os_cnt;
    logic            r_parity;     // Running parity over sent bits
    logic            w_bit_end;    // Last tick of a bit period
    bit_idx_t        w_last_bit;
    logic            w_two_stop;
    logic            w_tx_bit;

    // ======================================================================
    // Bit timing
    // ======================================================================
    // Free-running, so idle start latency depends on its phase
    always_ff @(posedge clk) begin
        if (cmd_tx_fifo_reset) begin
            r_os_cnt <= '0;
        end else if (baud_tick) begin
            r_os_cnt <= r_os_cnt + 1'b1;
        end
    end

    assign w_bit_end = baud_tick && (r_os_cnt == OS_LAST);

    // Word length code 0..3 maps to last index 4..7
    assign w_last_bit = {1'b1, frame_cfg.word_len};

    // 5-bit words always get a single stop bit
    assign w_two_stop = frame_cfg.two_stop && (frame_cfg.word_len != word_len_t'(0));

    // Pop pulse lines up with the load of the shift register
    assign fifo_pop = w_bit_end && (r_state == TX_IDLE) && !fifo_empty;

    // ======================================================================
    // Frame FSM
    // ======================================================================
    always_ff @(posedge clk) begin
        if (cmd_tx_fifo_reset) begin
            r_state   <= TX_IDLE;
            r_shift   <= '0;
            r_bit_idx <= '0;
            r_parity  <= 1'b0;
        end else if (w_bit_end) begin
            case (r_state)
                TX_IDLE: begin
                    if (fifo_pop) begin
                        r_shift  <= head_data;
                        r_parity <= ~frame_cfg.even_parity;  // 0 even, 1 odd
                        r_state  <= TX_START;
                    end
                end

                TX_START: begin
                    r_bit_idx <= '0;
                    r_state   <= TX_DATA;
                end

                TX_DATA: begin
                    r_parity <= r_parity ^ r_shift[0];
                    r_shift  <= {1'b0, r_shift[7:1]};
                    if (r_bit_idx == w_last_bit) begin
                        r_state <= frame_cfg.parity_en ? TX_PARITY : TX_STOP1;
                    end else begin
                        r_bit_idx <= r_bit_idx + 1'b1;
                    end
                end

                TX_PARITY: begin
                    r_state <= TX_STOP1;
                end

                TX_STOP1: begin
                    r_state <= w_two_stop ? TX_STOP2 : TX_IDLE;
                end

                TX_STOP2: begin
                    r_state <= TX_IDLE;
                end

                default: begin
                    r_state <= TX_IDLE;
                end
            endcase
        end
    end

    // ======================================================================
    // Line driver
    // ======================================================================
    always_comb begin
        case (r_state)
            TX_IDLE:   w_tx_bit = 1'b1;
            TX_START:  w_tx_bit = 1'b0;
            TX_DATA:   w_tx_bit = r_shift[0];
            TX_PARITY: begin
                // Stick parity sends mark for odd, space for even
                w_tx_bit = frame_cfg.stick_parity ? ~frame_cfg.even_parity : r_parity;
            end
            TX_STOP1:  w_tx_bit = 1'b1;
            TX_STOP2:  w_tx_bit = 1'b1;
            default:   w_tx_bit = 1'b1;
        endcase
    end

    assign uart_tx = set_break ? 1'b0 : w_tx_bit;  // Break overrides everything

    // Nothing queued and nothing on the wire
    assign tx_empty = fifo_empty && (r_state == TX_IDLE);

endmodule : uart_tx_serializer

// ==== uart_tx_top.sv ====
// Transmit-only UART; no handshake toward the host, a write into a full FIFO is lost
module uart_tx_top
    import uart_tx_pkg::*;
#(
    parameter int FIFO_DEPTH = 16   // Power of two, 2 or more
) (
    input  logic          clk,
    input  logic          cmd_tx_fifo_reset,
    input  logic          tx_write,      // One-cycle write strobe
    input  logic          set_break,
    input  baud_div_t     divisor,
    input  tx_frame_cfg_t frame_cfg,
    input  uart_byte_t    tx_data,
    output logic          uart_tx,
    output logic          tx_holding_empty,
    output logic          tx_empty
);

    // ======================================================================
    // Internal wiring
    // ======================================================================
    logic       w_baud_tick;
    logic       w_fifo_empty;
    logic       w_fifo_pop;
    uart_byte_t w_head_data;

    // 16x oversample pacing
    uart_baud_gen i_baud_gen (
        .clk               (clk),
        .cmd_tx_fifo_reset (cmd_tx_fifo_reset),
        .divisor           (divisor),
        .baud_tick         (w_baud_tick)
    );

    uart_tx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_tx_fifo (
        .clk               (clk),
        .cmd_tx_fifo_reset (cmd_tx_fifo_reset),
        .tx_write          (tx_write),
        .fifo_pop          (w_fifo_pop),
        .tx_data           (tx_data),
        .head_data         (w_head_data),
        .fifo_empty        (w_fifo_empty)
    );

    uart_tx_serializer i_serializer (
        .clk               (clk),
        .cmd_tx_fifo_reset (cmd_tx_fifo_reset),
        .baud_tick         (w_baud_tick),
        .set_break         (set_break),
        .fifo_empty        (w_fifo_empty),
        .frame_cfg         (frame_cfg),
        .head_data         (w_head_data),
        .fifo_pop          (w_fifo_pop),
        .uart_tx           (uart_tx),
        .tx_empty          (tx_empty)
    );

    // Holding register status is the FIFO empty flag
    assign tx_holding_empty = w_fifo_empty;

endmodule : uart_tx_top

// ==== tb_clock_gen.sv ====
// Testbench clock of PERIOD units; reset high from time 0, released on a falling edge
module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic cmd_tx_fifo_reset
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

    initial begin
        cmd_tx_fifo_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        cmd_tx_fifo_reset = 1'b0;   // Inputs change on the falling edge
    end

endmodule : tb_clock_gen

// ==== uart_tx_sva.sv ====
// Serializer protocol checks, bound into every uart_tx_serializer instance
module uart_tx_sva
    import uart_tx_pkg::*;
(
    input logic      clk,
    input logic      cmd_tx_fifo_reset,
    input logic      baud_tick,
    input logic      set_break,
    input logic      fifo_empty,
    input logic      fifo_pop,
    input logic      uart_tx,
    input tx_state_t state
);

    // A frame never starts from an empty FIFO
    assert property (@(posedge clk) disable iff (cmd_tx_fifo_reset)
        (state == TX_IDLE && fifo_empty) |=> (state == TX_IDLE))
        else $error("serializer left TX_IDLE with the FIFO empty");

    // Each pop begins a frame at the same edge
    assert property (@(posedge clk) disable iff (cmd_tx_fifo_reset)
        fifo_pop |=> (state == TX_START))
        else $error("fifo_pop not followed by TX_START");

    // Idle line is mark unless a break is forced
    assert property (@(posedge clk) disable iff (cmd_tx_fifo_reset)
        (state == TX_IDLE && !set_break) |-> uart_tx)
        else $error("uart_tx low in TX_IDLE without a break");

    // FSM only moves on a baud tick
    assert property (@(posedge clk) disable iff (cmd_tx_fifo_reset)
        !baud_tick |=> $stable(state))
        else $error("serializer state changed without baud_tick");

endmodule : uart_tx_sva

bind uart_tx_serializer uart_tx_sva i_sva (
    .clk               (clk),
    .cmd_tx_fifo_reset (cmd_tx_fifo_reset),
    .baud_tick         (baud_tick),
    .set_break         (set_break),
    .fifo_empty        (fifo_empty),
    .fifo_pop          (fifo_pop),
    .uart_tx           (uart_tx),
    .state             (r_state)
);

// ==== uart_tx_tb.sv ====
// Directed tests; the line decoder assumes the frame format stays fixed during each frame
module uart_tx_tb
    import uart_tx_pkg::*;
;

    logic          clk;
    logic          cmd_tx_fifo_reset;
    logic          tx_write;
    logic          set_break;
    baud_div_t     divisor;
    tx_frame_cfg_t frame_cfg;
    uart_byte_t    tx_data;
    logic          uart_tx;
    logic          tx_holding_empty;
    logic          tx_empty;

    int err_count;
    int test_count;
    int failed_tests;
    int test_err_start;

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(5)) i_clk_gen (
        .clk               (clk),
        .cmd_tx_fifo_reset (cmd_tx_fifo_reset)
    );

    uart_tx_top #(.FIFO_DEPTH(16)) i_dut (
        .clk               (clk),
        .cmd_tx_fifo_reset (cmd_tx_fifo_reset),
        .tx_write          (tx_write),
        .set_break         (set_break),
        .divisor           (divisor),
        .frame_cfg         (frame_cfg),
        .tx_data           (tx_data),
        .uart_tx           (uart_tx),
        .tx_holding_empty  (tx_holding_empty),
        .tx_empty          (tx_empty)
    );

    // ======================================================================
    // Compare tasks and helpers
    // ======================================================================
    task automatic compare_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s flag: got 0x%h, expected 0x%h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        err_count++;
    endtask

    task automatic start_test();
        test_err_start = err_count;
        test_count++;
    endtask

    task automatic end_test(input string name);
        if (err_count == test_err_start) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, err_count - test_err_start);
            failed_tests++;
        end
    endtask

    function automatic int bit_cycles();
        return OVERSAMPLE * ((divisor == '0) ? 1 : int'(divisor));  // Zero acts as one
    endfunction

    task automatic write_byte(input uart_byte_t b);
        tx_data  = b;
        tx_write = 1'b1;
        @(negedge clk);
        tx_write = 1'b0;
    endtask

    task automatic wait_tx_empty();
        int waited;
        waited = 0;
        while (!tx_empty && waited < 40 * bit_cycles()) begin
            @(negedge clk);
            waited++;
        end
        if (!tx_empty) report_error("tx_empty did not rise after the last frame");
    endtask

    // Serial decoder, samples each bit in its middle
    task automatic receive_frame(input int nbits, input bit has_par, input int nstop,
                                 output uart_byte_t data, output logic par,
                                 output logic [1:0] stops, output bit got);
        int   bt;
        int   waited;
        logic prev;
        bt     = bit_cycles();
        data   = '0;
        par    = 1'b0;
        stops  = 2'b11;
        got    = 1'b0;
        waited = 0;
        prev   = uart_tx;
        while (!got && waited < 20 * bt) begin   // Covers worst start latency
            @(negedge clk);
            if (prev && !uart_tx) got = 1'b1;
            prev = uart_tx;
            waited++;
        end
        if (got) begin
            repeat (bt / 2) @(negedge clk);
            compare_bit("uart_tx start bit", uart_tx, 1'b0);
            for (int i = 0; i < nbits; i++) begin
                repeat (bt) @(negedge clk);
                data[i] = uart_tx;
            end
            if (has_par) begin
                repeat (bt) @(negedge clk);
                par = uart_tx;
            end
            for (int i = 0; i < nstop; i++) begin
                repeat (bt) @(negedge clk);
                stops[i] = uart_tx;
            end
        end
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic test_reset_state();
        start_test();
        compare_flag("tx_holding_empty", tx_holding_empty, 1'b1);
        compare_flag("tx_empty", tx_empty, 1'b1);
        for (int i = 0; i < 100; i++) begin
            @(negedge clk);
            compare_bit("uart_tx idle", uart_tx, 1'b1);
        end
        end_test("reset_state");
    endtask

    task automatic test_stream();
        uart_byte_t bytes [8];
        start_test();
        divisor   = baud_div_t'(2);
        frame_cfg = '{word_len: word_len_t'(3), default: 1'b0};
        foreach (bytes[i]) bytes[i] = uart_byte_t'($urandom);
        fork
            begin
                foreach (bytes[i]) write_byte(bytes[i]);
            end
            begin
                uart_byte_t d;
                logic       p;
                logic [1:0] s;
                bit         got;
                foreach (bytes[i]) begin
                    receive_frame(8, 1'b0, 1, d, p, s, got);
                    if (!got) begin
                        report_error($sformatf("no start bit for stream byte %0d", i));
                    end else begin
                        compare_byte("uart_tx data", d, bytes[i]);
                        compare_bit("uart_tx stop bit", s[0], 1'b1);
                    end
                end
            end
        join
        // Last frame still in its stop bit
        compare_flag("tx_empty", tx_empty, 1'b0);
        wait_tx_empty();
        end_test("stream_8n1");
    endtask

    task automatic test_word_lengths();
        uart_byte_t b;
        uart_byte_t d;
        uart_byte_t mask;
        logic       p;
        logic [1:0] s;
        bit         got;
        start_test();
        divisor = baud_div_t'(3);
        for (int wl = 0; wl < 4; wl++) begin
            frame_cfg = '{word_len: word_len_t'(wl), two_stop: 1'b1, default: 1'b0};
            b    = uart_byte_t'($urandom);
            mask = uart_byte_t'((1 << (5 + wl)) - 1);
            write_byte(b);
            receive_frame(5 + wl, 1'b0, 2, d, p, s, got);
            if (!got) begin
                report_error($sformatf("no frame for word length %0d", 5 + wl));
            end else begin
                compare_byte("uart_tx data", d, b & mask);
                compare_bit("uart_tx stop bit 1", s[0], 1'b1);
                compare_bit("uart_tx stop bit 2", s[1], 1'b1);
                // 5-bit frames end after one stop bit, longer ones still busy
                compare_flag("tx_empty", tx_empty, (wl == 0) ? 1'b1 : 1'b0);
            end
            wait_tx_empty();
        end
        end_test("word_lengths");
    endtask

    task automatic test_parity();
        uart_byte_t b;
        uart_byte_t d;
        logic       p;
        logic       exp_p;
        logic [1:0] s;
        bit         got;
        int         nbits;
        start_test();
        divisor = baud_div_t'(2);
        for (int k = 0; k < 8; k++) begin
            frame_cfg.word_len     = (k[2]) ? word_len_t'(1) : word_len_t'(3);
            frame_cfg.two_stop     = 1'b0;
            frame_cfg.parity_en    = 1'b1;
            frame_cfg.even_parity  = k[0];
            frame_cfg.stick_parity = k[1];
            nbits = 5 + int'(frame_cfg.word_len);
            b = uart_byte_t'($urandom) & uart_byte_t'((1 << nbits) - 1);
            if (frame_cfg.stick_parity) exp_p = ~frame_cfg.even_parity;
            else exp_p = frame_cfg.even_parity ? (^b) : ~(^b);   // Odd inverts
            write_byte(b);
            receive_frame(nbits, 1'b1, 1, d, p, s, got);
            if (!got) begin
                report_error($sformatf("no frame in parity case %0d", k));
            end else begin
                compare_byte("uart_tx data", d, b);
                compare_bit("uart_tx parity bit", p, exp_p);
                compare_bit("uart_tx stop bit", s[0], 1'b1);
            end
            wait_tx_empty();
        end
        end_test("parity");
    endtask

    task automatic test_break();
        int highs;
        start_test();
        highs = 0;
        set_break = 1'b1;
        @(negedge clk);
        repeat (12 * bit_cycles()) begin   // One full frame and more
            if (uart_tx !== 1'b0) highs++;
            @(negedge clk);
        end
        if (highs != 0) report_error($sformatf("uart_tx was high in %0d cycles of break", highs));
        set_break = 1'b0;
        @(negedge clk);
        compare_bit("uart_tx after break", uart_tx, 1'b1);
        compare_flag("tx_empty", tx_empty, 1'b1);
        end_test("break");
    endtask

    task automatic test_overflow();
        uart_byte_t bytes [17];
        uart_byte_t d;
        logic       p;
        logic [1:0] s;
        bit         got;
        start_test();
        divisor   = baud_div_t'(4);
        frame_cfg = '{word_len: word_len_t'(3), default: 1'b0};
        // Priming frame fixes the bit phase, next bit end is a full bit away
        write_byte(8'h5a);
        receive_frame(8, 1'b0, 1, d, p, s, got);
        if (!got) report_error("priming frame missing");
        wait_tx_empty();
        foreach (bytes[i]) bytes[i] = uart_byte_t'($urandom);
        foreach (bytes[i]) write_byte(bytes[i]);
        compare_flag("tx_holding_empty", tx_holding_empty, 1'b0);
        for (int i = 0; i < 16; i++) begin
            receive_frame(8, 1'b0, 1, d, p, s, got);
            if (!got) begin
                report_error($sformatf("queued byte %0d never transmitted", i));
            end else begin
                compare_byte("uart_tx data", d, bytes[i]);
            end
        end
        receive_frame(8, 1'b0, 1, d, p, s, got);   // Timeout expected here
        if (got) report_error("byte written into a full FIFO was transmitted");
        compare_flag("tx_holding_empty", tx_holding_empty, 1'b1);
        compare_flag("tx_empty", tx_empty, 1'b1);
        end_test("overflow");
    endtask

    // ======================================================================
    // Sequencer
    // ======================================================================
    initial begin
        int waited;
        tx_write     = 1'b0;
        set_break    = 1'b0;
        tx_data      = '0;
        divisor      = baud_div_t'(2);
        frame_cfg    = '{word_len: word_len_t'(3), default: 1'b0};
        err_count    = 0;
        test_count   = 0;
        failed_tests = 0;
        void'($urandom(32'hb5f9));
        waited = 0;
        while (cmd_tx_fifo_reset !== 1'b0 && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (cmd_tx_fifo_reset !== 1'b0) report_error("reset never released");
        test_reset_state();
        test_stream();
        test_word_lengths();
        test_parity();
        test_break();
        test_overflow();
        $display("Tests run %0d, failed %0d, errors %0d", test_count, failed_tests, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Whole-run limit
    initial begin
        repeat (400000) @(posedge clk);
        $display("ERROR: simulation time limit reached");
        $display(">>> FAIL");
        $finish;
    end

endmodule : uart_tx_tb

// ==== verilog.f ====
uart_tx_pkg.sv
uart_baud_gen.sv
uart_tx_fifo.sv
uart_tx_serializer.sv
uart_tx_top.sv
tb_clock_gen.sv
uart_tx_sva.sv
uart_tx_tb.sv

// ==== Makefile ====
# Verilator build and run for the transmit-only UART testbench

VERILATOR ?= verilator
TOP       ?= uart_tx_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx ">>> PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
